/* i2s_dma_regs.f */
+incdir+include
verilog/i2s_map_pkg.sv
verilog/i2s_field_pkg.sv
verilog/wb_bus_decode.sv
verilog/ctrl_regs.sv
verilog/irq_regs.sv
verilog/reg_read_mux.sv
verilog/i2s_dma_regs.sv
tb/tb_i2s_dma_regs.sv

/* include/tb_i2s_dma_ref.svh */
`ifndef TB_I2S_DMA_REF_SVH
`define TB_I2S_DMA_REF_SVH

// Bus windows and event inputs of the DUT
localparam int WIN_REG  = 0;
localparam int WIN_REAL = 1;
localparam int WIN_IMG  = 2;
localparam int WIN_COS  = 3;

localparam int EV_DMA_DONE = 0;
localparam int EV_I2S_DIS  = 1;
localparam int EV_F_DONE   = 2;
localparam int EV_ACTIVE   = 3;
localparam int EV_CLR      = 4;

// ----------------------------------------------------------------------
// Shadow model state
// ----------------------------------------------------------------------
logic       m_ack;      // Expected ack level
logic       m_hold;     // Quiet cycle after an ack
logic       m_en;
logic       m_mast;
logic       m_csrd;
logic       m_rst_pls;
logic       m_dma_en;
logic       m_start;    // Start latch before the enable gate
logic [2:0] m_sts;      // Slots 0 DMA done, 1 I2S disable, 2 filter done
logic [2:0] m_ien;
dma_cnt_t   m_cnt;

task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
	if (act !== exp)
	begin
		$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_with_failure();
	end
endtask

task automatic check_cnt(input string name, input dma_cnt_t exp, input dma_cnt_t act);
	if (act !== exp)
	begin
		$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		stop_with_failure();
	end
endtask

task automatic reset_model();
	m_ack     = 1'b0;
	m_hold    = 1'b0;
	m_en      = 1'b1;  // Receiver on out of reset
	m_mast    = 1'b0;
	m_csrd    = 1'b0;
	m_rst_pls = 1'b0;
	m_dma_en  = 1'b0;
	m_start   = 1'b0;
	m_sts     = 3'b000;
	m_ien     = 3'b000;
	m_cnt     = 9'd4;
endtask

// Register word as the map defines it
function automatic wb_dat_t expected_word(input wb_adr_t adr);
	wb_dat_t w;
	w = '0;
	case (adr)
		I2S_EN_ADR:   w = {28'd0, m_csrd, 1'b0, m_mast, m_en};
		INTR_STS_ADR: w = {28'd0, m_sts[1], m_sts[2], 1'b0, m_sts[0]};
		INTR_EN_ADR:  w = {28'd0, m_ien[1], 1'b0, m_ien[2], m_ien[0]};
		DMA_EN_ADR:   w = {31'd0, m_dma_en};
		DMA_CNT_ADR:  w = {23'd0, m_cnt};
		DMA_STS_ADR:  w = {dma_st_i, 5'd0, dma_cntr_i, m_start & m_dma_en, 11'd0,
		                   DMA_REQ_i, DMA_Active_i, m_sts[0], DMA_Busy_i};
		default:      w = '0;
	endcase
	return w;
endfunction

task automatic check_outputs();
	logic sram_we;
	logic cs_we;
	sram_we = (WBs_CYC_I2SRx_Real_RAM_i | WBs_CYC_I2SRx_Img_RAM_i) & WBs_STB_i & WBs_WE_i
	          & ~m_ack;
	cs_we   = WBs_CYC_f_CosSin_RAM_i & WBs_STB_i & WBs_WE_i & ~m_ack;
	check_bit("WBs_ACK_o", m_ack, WBs_ACK_o);
	if (m_ack && WBs_CYC_i && !WBs_WE_i)
		check_word("WBs_DAT_o", expected_word(WBs_ADR_i), WBs_DAT_o);
	check_bit("I2S_S_EN_o", m_en, I2S_S_EN_o);
	check_bit("f_RAM_mast_sel_o", m_mast, f_RAM_mast_sel_o);
	check_bit("cs_ram_rd_ctrl_o", m_csrd, cs_ram_rd_ctrl_o);
	check_bit("RAM_logic_rst_o", m_rst_pls, RAM_logic_rst_o);
	check_bit("DMA_Start_o", m_start & m_dma_en, DMA_Start_o);
	check_cnt("DMA_CNT_o", m_cnt, DMA_CNT_o);
	check_bit("DMA_Done_IRQ_o", m_sts[0], DMA_Done_IRQ_o);
	check_bit("I2S_Dis_IRQ_o", m_sts[1], I2S_Dis_IRQ_o);
	check_bit("f_Done_IRQ_o", m_sts[2], f_Done_IRQ_o);
	check_bit("DMA_Done_IRQ_EN_o", m_ien[0], DMA_Done_IRQ_EN_o);
	check_bit("I2S_Dis_IRQ_EN_o", m_ien[1], I2S_Dis_IRQ_EN_o);
	check_bit("f_Done_IRQ_EN_o", m_ien[2], f_Done_IRQ_EN_o);
	check_bit("wb_L_f_RAM_Wen_o", sram_we, wb_L_f_RAM_Wen_o);
	check_bit("wb_CosSin_RAM_Wen_o", cs_we, wb_CosSin_RAM_Wen_o);
	check_word("wb_L_f_RAM_aDDR_o", WBs_ADR_i, wb_L_f_RAM_aDDR_o);
	check_word("wb_CosSin_RAM_aDDR_o", WBs_ADR_i & 10'h1FF, wb_CosSin_RAM_aDDR_o);
	check_word("wb_CosSin_RAM_Data_o", WBs_DAT_i, wb_CosSin_RAM_Data_o);
	check_word("WBs_CosSin_RAM_DAT_o", wb_CosSin_RAM_Data_i, WBs_CosSin_RAM_DAT_o);
	check_word("WBs_f_RealImg_RAM_DAT_o", {wb_L_f_Real_RAM_Data_i, wb_L_f_Img_RAM_Data_i},
	           WBs_f_RealImg_RAM_DAT_o);
endtask

// One clock of the register rules from the inputs before the edge
task automatic advance_model();
	logic    cyc_open;
	logic    wr;
	logic    nxt_ack;
	wb_dat_t d;
	d        = WBs_DAT_i;
	cyc_open = (WBs_CYC_i | WBs_CYC_I2SRx_Real_RAM_i | WBs_CYC_I2SRx_Img_RAM_i
	           | WBs_CYC_f_CosSin_RAM_i) & WBs_STB_i;
	wr       = WBs_CYC_i & WBs_STB_i & WBs_WE_i & WBs_BYTE_STB_i[0] & ~m_ack;
	m_rst_pls = wr && (WBs_ADR_i == I2S_EN_ADR) && d[4];
	if (wr && WBs_ADR_i == I2S_EN_ADR)
	begin
		m_en   = d[0];
		m_mast = d[1];
		m_csrd = d[3];
	end
	else if (i2s_dis_i)
		m_en = 1'b0;
	if (wr && WBs_ADR_i == DMA_EN_ADR)
		m_dma_en = d[0];
	else if (DMA_Clr_i)
		m_dma_en = 1'b0;
	if (wr && WBs_ADR_i == DMA_CNT_ADR)
		m_cnt = d[8:0];
	if (wr && WBs_ADR_i == INTR_EN_ADR)
		m_ien = {d[1], d[3], d[0]};
	if (wr && WBs_ADR_i == INTR_STS_ADR)
		m_sts = {d[2], d[3], d[0]};
	m_sts = m_sts | {f_calc_done_i, i2s_dis_i, DMA_Done_i};  // Event wins
	if (f_calc_done_i)
		m_start = 1'b1;
	else if (DMA_Active_i)
		m_start = 1'b0;
	nxt_ack = cyc_open & ~m_ack & ~m_hold;
	m_hold  = m_ack;
	m_ack   = nxt_ack;
endtask

// ----------------------------------------------------------------------
// Bus and event drivers called on the falling edge
// ----------------------------------------------------------------------
task automatic idle_bus();
	WBs_CYC_i                = 1'b0;
	WBs_CYC_I2SRx_Real_RAM_i = 1'b0;
	WBs_CYC_I2SRx_Img_RAM_i  = 1'b0;
	WBs_CYC_f_CosSin_RAM_i   = 1'b0;
	WBs_STB_i                = 1'b0;
	WBs_WE_i                 = 1'b0;
	WBs_ADR_i                = '0;
	WBs_DAT_i                = '0;
	WBs_BYTE_STB_i           = '0;
endtask

task automatic bus_access(input int win, input logic we, input wb_adr_t adr,
                          input wb_dat_t dat, input wb_bstb_t bstb);
	int waited;
	@(negedge WBs_CLK_i);
	WBs_CYC_i                = (win == WIN_REG);
	WBs_CYC_I2SRx_Real_RAM_i = (win == WIN_REAL);
	WBs_CYC_I2SRx_Img_RAM_i  = (win == WIN_IMG);
	WBs_CYC_f_CosSin_RAM_i   = (win == WIN_COS);
	WBs_STB_i                = 1'b1;
	WBs_WE_i                 = we;
	WBs_ADR_i                = adr;
	WBs_DAT_i                = dat;
	WBs_BYTE_STB_i           = bstb;
	waited = 0;
	do
	begin
		@(posedge WBs_CLK_i);
		waited++;
	end
	while (WBs_ACK_o !== 1'b1 && waited < 6);
	if (WBs_ACK_o !== 1'b1)
	begin
		$display("bus cycle to offset %h got no acknowledge", adr);
		stop_with_failure();
	end
	@(negedge WBs_CLK_i);
	idle_bus();
endtask

task automatic reg_write(input wb_adr_t adr, input wb_dat_t dat);
	bus_access(WIN_REG, 1'b1, adr, dat, 4'hF);
endtask

task automatic reg_read(input wb_adr_t adr);
	bus_access(WIN_REG, 1'b0, adr, '0, 4'hF);
endtask

// Acks counted while a read strobe is held
task automatic held_read(input wb_adr_t adr, input int cycles);
	int acks;
	acks = 0;
	@(negedge WBs_CLK_i);
	WBs_CYC_i = 1'b1;
	WBs_STB_i = 1'b1;
	WBs_ADR_i = adr;
	repeat (cycles)
	begin
		@(posedge WBs_CLK_i);
		if (WBs_ACK_o === 1'b1)
			acks++;
	end
	@(negedge WBs_CLK_i);
	idle_bus();
	check_word("ack count", (cycles + 1) / 3, acks);  // One ack in three clocks
endtask

task automatic set_event(input int ev, input logic val);
	case (ev)
		EV_DMA_DONE: DMA_Done_i    = val;
		EV_I2S_DIS:  i2s_dis_i     = val;
		EV_F_DONE:   f_calc_done_i = val;
		EV_ACTIVE:   DMA_Active_i  = val;
		default:     DMA_Clr_i     = val;
	endcase
endtask

task automatic pulse_event(input int ev);
	@(negedge WBs_CLK_i);
	set_event(ev, 1'b1);
	@(negedge WBs_CLK_i);
	set_event(ev, 1'b0);
endtask

`endif

/* tb/tb_i2s_dma_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_i2s_dma_regs;

	import i2s_map_pkg::*;
	import i2s_field_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 16;
	localparam int N_RAND     = 16;   // Random register writes
	localparam int N_TRANS    = 100;  // Bus cycles and pulses rounded up
	localparam int WD_CYCLES  = RST_CYCLES + N_TRANS * 3 + 200;

	// DUT inputs
	logic                  WBs_CLK_i;
	logic                  WBs_RST_i;
	wb_adr_t               WBs_ADR_i;
	logic                  WBs_CYC_i;
	logic                  WBs_CYC_I2SRx_Real_RAM_i;
	logic                  WBs_CYC_I2SRx_Img_RAM_i;
	logic                  WBs_CYC_f_CosSin_RAM_i;
	wb_bstb_t              WBs_BYTE_STB_i;
	logic                  WBs_WE_i;
	logic                  WBs_STB_i;
	wb_dat_t               WBs_DAT_i;
	logic                  i2s_dis_i;
	logic                  f_calc_done_i;
	logic [RAM_HALF_W-1:0] wb_L_f_Real_RAM_Data_i;
	logic [RAM_HALF_W-1:0] wb_L_f_Img_RAM_Data_i;
	wb_dat_t               wb_CosSin_RAM_Data_i;
	logic                  DMA_Busy_i;
	logic                  DMA_Clr_i;
	logic                  DMA_Done_i;
	logic                  DMA_Active_i;
	logic                  DMA_REQ_i;
	dma_cnt_t              dma_cntr_i;
	logic [DMA_ST_W-1:0]   dma_st_i;

	// DUT outputs
	wb_dat_t               WBs_DAT_o;
	wb_dat_t               WBs_CosSin_RAM_DAT_o;
	wb_dat_t               WBs_f_RealImg_RAM_DAT_o;
	logic                  WBs_ACK_o;
	logic                  I2S_S_EN_o;
	logic                  f_RAM_mast_sel_o;
	logic                  cs_ram_rd_ctrl_o;
	logic                  RAM_logic_rst_o;
	wb_adr_t               wb_L_f_RAM_aDDR_o;
	logic                  wb_L_f_RAM_Wen_o;
	wb_adr_t               wb_CosSin_RAM_aDDR_o;
	logic                  wb_CosSin_RAM_Wen_o;
	wb_dat_t               wb_CosSin_RAM_Data_o;
	dma_cnt_t              DMA_CNT_o;
	logic                  DMA_Start_o;
	logic                  DMA_Done_IRQ_o;
	logic                  DMA_Done_IRQ_EN_o;
	logic                  I2S_Dis_IRQ_o;
	logic                  I2S_Dis_IRQ_EN_o;
	logic                  f_Done_IRQ_o;
	logic                  f_Done_IRQ_EN_o;

	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

`include "tb_i2s_dma_ref.svh"

	i2s_dma_regs uut (.*);

	always #(CLK_PERIOD / 2) WBs_CLK_i = ~WBs_CLK_i;

	// Model steps after each compare
	always @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			reset_model();
		else
		begin
			check_outputs();
			advance_model();
		end
	end

	initial
	begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the sequence did not finish in %0d cycles", WD_CYCLES);
		stop_with_failure();
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	initial
	begin
		wb_adr_t adr;
		void'($urandom(66177));
		WBs_CLK_i = 1'b0;
		WBs_RST_i = 1'b1;
		idle_bus();
		for (int k = 0; k <= EV_CLR; k++)
			set_event(k, 1'b0);
		wb_L_f_Real_RAM_Data_i = '0;
		wb_L_f_Img_RAM_Data_i  = '0;
		wb_CosSin_RAM_Data_i   = '0;
		DMA_Busy_i = 1'b0;
		DMA_REQ_i  = 1'b0;
		dma_cntr_i = '0;
		dma_st_i   = '0;
		repeat (RST_CYCLES) @(posedge WBs_CLK_i);
		@(negedge WBs_CLK_i);
		WBs_RST_i = 1'b0;

		// Reset values and unmapped offsets
		for (int a = 0; a < 16; a++)
			reg_read(wb_adr_t'(a));
		repeat (4) reg_read(wb_adr_t'($urandom));

		for (int n = 0; n < N_RAND; n++)
		begin
			case ($urandom % 4)
				0:       adr = I2S_EN_ADR;
				1:       adr = DMA_EN_ADR;
				2:       adr = DMA_CNT_ADR;
				default: adr = INTR_EN_ADR;
			endcase
			reg_write(adr, $urandom);
			reg_read(adr);
		end
		reg_write(I2S_EN_ADR, 32'h0000_001B);  // RAM reset pulse with the receiver on
		bus_access(WIN_REG, 1'b1, DMA_CNT_ADR, 32'h0000_01FF, 4'b1110);
		reg_read(DMA_CNT_ADR);
		held_read(I2S_EN_ADR, 9);

		// RAM windows
		wb_L_f_Real_RAM_Data_i = 16'($urandom);
		wb_L_f_Img_RAM_Data_i  = 16'($urandom);
		wb_CosSin_RAM_Data_i   = $urandom;
		bus_access(WIN_REAL, 1'b1, wb_adr_t'($urandom), $urandom, 4'hF);
		bus_access(WIN_IMG, 1'b1, wb_adr_t'($urandom), $urandom, 4'hF);
		bus_access(WIN_COS, 1'b1, 10'h3C5, $urandom, 4'hF);
		bus_access(WIN_REAL, 1'b0, wb_adr_t'($urandom), '0, 4'hF);
		bus_access(WIN_COS, 1'b0, 10'h2A0, '0, 4'hF);

		// DMA start, active and clear
		reg_write(DMA_EN_ADR, 32'd0);
		pulse_event(EV_F_DONE);
		reg_read(DMA_STS_ADR);
		reg_write(DMA_EN_ADR, 32'd1);
		reg_read(DMA_STS_ADR);
		pulse_event(EV_ACTIVE);
		pulse_event(EV_F_DONE);
		pulse_event(EV_CLR);
		reg_read(DMA_EN_ADR);
		repeat (4)
		begin
			DMA_Busy_i   = 1'($urandom);
			DMA_REQ_i    = 1'($urandom);
			DMA_Active_i = 1'($urandom);
			dma_cntr_i   = 9'($urandom);
			dma_st_i     = 2'($urandom);
			reg_read(DMA_STS_ADR);
		end
		DMA_Active_i = 1'b0;

		// Interrupt status set and clear
		reg_write(INTR_STS_ADR, 32'd0);
		pulse_event(EV_DMA_DONE);
		pulse_event(EV_I2S_DIS);
		pulse_event(EV_F_DONE);
		reg_read(INTR_STS_ADR);
		reg_read(I2S_EN_ADR);
		reg_write(INTR_STS_ADR, 32'd0);
		reg_read(INTR_STS_ADR);
		fork
			reg_write(INTR_STS_ADR, 32'd0);
			pulse_event(EV_F_DONE);  // Same edge as the clearing write
		join
		reg_read(INTR_STS_ADR);

		repeat (4) @(negedge WBs_CLK_i);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
	input  wire                     WBs_CLK_i,
	input  wire                     WBs_RST_i,
	input  wire                     wr_ctrl_i,
	input  wire                     wr_dma_en_i,
	input  wire                     wr_dma_cnt_i,
	input  wire                     i2s_dis_i,
	input  wire                     f_calc_done_i,
	input  wire                     DMA_Active_i,
	input  wire                     DMA_Clr_i,
	input  i2s_map_pkg::wb_dat_t    WBs_DAT_i,
	output logic                    I2S_S_EN_o,
	output logic                    f_RAM_mast_sel_o,
	output logic                    cs_ram_rd_ctrl_o,
	output logic                    RAM_logic_rst_o,
	output logic                    dma_en_o,
	output logic                    DMA_Start_o,
	output i2s_field_pkg::dma_cnt_t DMA_CNT_o
);

	import i2s_field_pkg::*;

	logic start_q;  // Pending DMA start from the filter

	// ------------------------------------------------------------------
	// Control word
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			I2S_S_EN_o       <= I2S_EN_RST;
			f_RAM_mast_sel_o <= 1'b0;
			cs_ram_rd_ctrl_o <= 1'b0;
		end
		else
		begin
			if (wr_ctrl_i)
			begin
				I2S_S_EN_o       <= WBs_DAT_i[CTRL_I2S_EN_BIT];
				f_RAM_mast_sel_o <= WBs_DAT_i[CTRL_MAST_SEL_BIT];
				cs_ram_rd_ctrl_o <= WBs_DAT_i[CTRL_CS_RD_BIT];
			end
			else if (i2s_dis_i)
			begin
				I2S_S_EN_o <= 1'b0;  // Receiver dropped out
			end
		end
	end

	// One shot, never held past a single cycle
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			RAM_logic_rst_o <= 1'b0;
		else
			RAM_logic_rst_o <= wr_ctrl_i & WBs_DAT_i[CTRL_RAM_RST_BIT];
	end

	// ------------------------------------------------------------------
	// DMA enable and transfer count
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			dma_en_o  <= 1'b0;
			DMA_CNT_o <= DMA_CNT_RST;
		end
		else
		begin
			if (wr_dma_en_i)
				dma_en_o <= WBs_DAT_i[0];
			else if (DMA_Clr_i)
				dma_en_o <= 1'b0;  // Engine finished its block

			if (wr_dma_cnt_i)
				DMA_CNT_o <= WBs_DAT_i[DMA_CNT_W-1:0];
		end
	end

	// Filter done requests a transfer until the engine picks it up
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			start_q <= 1'b0;
		else if (f_calc_done_i)
			start_q <= 1'b1;
		else if (DMA_Active_i)
			start_q <= 1'b0;
	end

	assign DMA_Start_o = start_q & dma_en_o;

endmodule

`default_nettype wire

/* verilog/i2s_dma_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_dma_regs (
	input  wire                     WBs_CLK_i,
	input  wire                     WBs_RST_i,

	// Register and RAM bus
	input  i2s_map_pkg::wb_adr_t    WBs_ADR_i,
	input  wire                     WBs_CYC_i,
	input  wire                     WBs_CYC_I2SRx_Real_RAM_i,
	input  wire                     WBs_CYC_I2SRx_Img_RAM_i,
	input  wire                     WBs_CYC_f_CosSin_RAM_i,
	input  i2s_map_pkg::wb_bstb_t   WBs_BYTE_STB_i,
	input  wire                     WBs_WE_i,
	input  wire                     WBs_STB_i,
	input  i2s_map_pkg::wb_dat_t    WBs_DAT_i,
	output i2s_map_pkg::wb_dat_t    WBs_DAT_o,
	output i2s_map_pkg::wb_dat_t    WBs_CosSin_RAM_DAT_o,
	output i2s_map_pkg::wb_dat_t    WBs_f_RealImg_RAM_DAT_o,  // Real high, Img low
	output logic                    WBs_ACK_o,

	// Receiver and filter control
	input  wire                     i2s_dis_i,
	input  wire                     f_calc_done_i,
	output logic                    I2S_S_EN_o,
	output logic                    f_RAM_mast_sel_o,
	output logic                    cs_ram_rd_ctrl_o,
	output logic                    RAM_logic_rst_o,

	// Sample RAM window
	output i2s_map_pkg::wb_adr_t    wb_L_f_RAM_aDDR_o,
	output logic                    wb_L_f_RAM_Wen_o,
	input  wire [i2s_map_pkg::RAM_HALF_W-1:0] wb_L_f_Real_RAM_Data_i,
	input  wire [i2s_map_pkg::RAM_HALF_W-1:0] wb_L_f_Img_RAM_Data_i,

	// Coefficient RAM window
	output i2s_map_pkg::wb_adr_t    wb_CosSin_RAM_aDDR_o,
	output logic                    wb_CosSin_RAM_Wen_o,
	output i2s_map_pkg::wb_dat_t    wb_CosSin_RAM_Data_o,
	input  i2s_map_pkg::wb_dat_t    wb_CosSin_RAM_Data_i,

	// DMA engine
	input  wire                     DMA_Busy_i,
	input  wire                     DMA_Clr_i,
	input  wire                     DMA_Done_i,
	input  wire                     DMA_Active_i,
	input  wire                     DMA_REQ_i,
	input  i2s_field_pkg::dma_cnt_t dma_cntr_i,
	input  wire [i2s_field_pkg::DMA_ST_W-1:0] dma_st_i,
	output i2s_field_pkg::dma_cnt_t DMA_CNT_o,
	output logic                    DMA_Start_o,

	// Interrupts
	output logic                    DMA_Done_IRQ_o,
	output logic                    DMA_Done_IRQ_EN_o,
	output logic                    I2S_Dis_IRQ_o,
	output logic                    I2S_Dis_IRQ_EN_o,
	output logic                    f_Done_IRQ_o,
	output logic                    f_Done_IRQ_EN_o
);

	import i2s_map_pkg::*;

	logic wr_ctrl;
	logic wr_dma_en;
	logic wr_dma_cnt;
	logic wr_irq_en;
	logic wr_irq_sts;
	logic dma_en;

	wb_bus_decode u_decode (
		.WBs_CLK_i                (WBs_CLK_i),
		.WBs_RST_i                (WBs_RST_i),
		.WBs_ADR_i                (WBs_ADR_i),
		.WBs_CYC_i                (WBs_CYC_i),
		.WBs_CYC_I2SRx_Real_RAM_i (WBs_CYC_I2SRx_Real_RAM_i),
		.WBs_CYC_I2SRx_Img_RAM_i  (WBs_CYC_I2SRx_Img_RAM_i),
		.WBs_CYC_f_CosSin_RAM_i   (WBs_CYC_f_CosSin_RAM_i),
		.WBs_STB_i                (WBs_STB_i),
		.WBs_WE_i                 (WBs_WE_i),
		.WBs_BYTE_STB_i           (WBs_BYTE_STB_i),
		.wr_ctrl_o                (wr_ctrl),
		.wr_dma_en_o              (wr_dma_en),
		.wr_dma_cnt_o             (wr_dma_cnt),
		.wr_irq_en_o              (wr_irq_en),
		.wr_irq_sts_o             (wr_irq_sts),
		.sram_wen_o               (wb_L_f_RAM_Wen_o),
		.cs_ram_wen_o             (wb_CosSin_RAM_Wen_o),
		.WBs_ACK_o                (WBs_ACK_o)
	);

	ctrl_regs u_ctrl (
		.WBs_CLK_i        (WBs_CLK_i),
		.WBs_RST_i        (WBs_RST_i),
		.wr_ctrl_i        (wr_ctrl),
		.wr_dma_en_i      (wr_dma_en),
		.wr_dma_cnt_i     (wr_dma_cnt),
		.i2s_dis_i        (i2s_dis_i),
		.f_calc_done_i    (f_calc_done_i),
		.DMA_Active_i     (DMA_Active_i),
		.DMA_Clr_i        (DMA_Clr_i),
		.WBs_DAT_i        (WBs_DAT_i),
		.I2S_S_EN_o       (I2S_S_EN_o),
		.f_RAM_mast_sel_o (f_RAM_mast_sel_o),
		.cs_ram_rd_ctrl_o (cs_ram_rd_ctrl_o),
		.RAM_logic_rst_o  (RAM_logic_rst_o),
		.dma_en_o         (dma_en),
		.DMA_Start_o      (DMA_Start_o),
		.DMA_CNT_o        (DMA_CNT_o)
	);

	irq_regs u_irq (
		.WBs_CLK_i         (WBs_CLK_i),
		.WBs_RST_i         (WBs_RST_i),
		.wr_irq_en_i       (wr_irq_en),
		.wr_irq_sts_i      (wr_irq_sts),
		.DMA_Done_i        (DMA_Done_i),
		.i2s_dis_i         (i2s_dis_i),
		.f_calc_done_i     (f_calc_done_i),
		.WBs_DAT_i         (WBs_DAT_i),
		.DMA_Done_IRQ_o    (DMA_Done_IRQ_o),
		.I2S_Dis_IRQ_o     (I2S_Dis_IRQ_o),
		.f_Done_IRQ_o      (f_Done_IRQ_o),
		.DMA_Done_IRQ_EN_o (DMA_Done_IRQ_EN_o),
		.I2S_Dis_IRQ_EN_o  (I2S_Dis_IRQ_EN_o),
		.f_Done_IRQ_EN_o   (f_Done_IRQ_EN_o)
	);

	reg_read_mux u_rd_mux (
		.WBs_ADR_i         (WBs_ADR_i),
		.I2S_S_EN_i        (I2S_S_EN_o),
		.f_RAM_mast_sel_i  (f_RAM_mast_sel_o),
		.cs_ram_rd_ctrl_i  (cs_ram_rd_ctrl_o),
		.dma_en_i          (dma_en),
		.DMA_Start_i       (DMA_Start_o),
		.DMA_CNT_i         (DMA_CNT_o),
		.DMA_Done_IRQ_i    (DMA_Done_IRQ_o),
		.I2S_Dis_IRQ_i     (I2S_Dis_IRQ_o),
		.f_Done_IRQ_i      (f_Done_IRQ_o),
		.DMA_Done_IRQ_EN_i (DMA_Done_IRQ_EN_o),
		.I2S_Dis_IRQ_EN_i  (I2S_Dis_IRQ_EN_o),
		.f_Done_IRQ_EN_i   (f_Done_IRQ_EN_o),
		.DMA_Busy_i        (DMA_Busy_i),
		.DMA_Active_i      (DMA_Active_i),
		.DMA_REQ_i         (DMA_REQ_i),
		.dma_cntr_i        (dma_cntr_i),
		.dma_st_i          (dma_st_i),
		.WBs_DAT_o         (WBs_DAT_o)
	);

	// ------------------------------------------------------------------
	// RAM pass-through
	// ------------------------------------------------------------------
	assign wb_L_f_RAM_aDDR_o       = WBs_ADR_i;
	assign WBs_f_RealImg_RAM_DAT_o = {wb_L_f_Real_RAM_Data_i, wb_L_f_Img_RAM_Data_i};

	// Coefficient RAM only spans the lower half of the window
	assign wb_CosSin_RAM_aDDR_o = {{(ADR_W-COS_SIN_ADR_W){1'b0}}, WBs_ADR_i[COS_SIN_ADR_W-1:0]};
	assign wb_CosSin_RAM_Data_o = WBs_DAT_i;
	assign WBs_CosSin_RAM_DAT_o = wb_CosSin_RAM_Data_i;

endmodule

`default_nettype wire

/* verilog/i2s_field_pkg.sv */
`default_nettype none

// ----------------------------------------------------------------------
// Field positions and reset values inside the register words
// ----------------------------------------------------------------------
package i2s_field_pkg;

	// Control word
	localparam int CTRL_I2S_EN_BIT   = 0;
	localparam int CTRL_MAST_SEL_BIT = 1;
	localparam int CTRL_CS_RD_BIT    = 3;
	localparam int CTRL_RAM_RST_BIT  = 4;  // Self clearing

	// Interrupt words
	localparam int IRQ_DMA_DONE_BIT   = 0;
	localparam int IRQ_F_DONE_BIT     = 1;  // Enable word only
	localparam int IRQ_F_DONE_STS_BIT = 2;  // Status word only
	localparam int IRQ_I2S_DIS_BIT    = 3;

	// DMA status word
	localparam int ST_BUSY      = 0;
	localparam int ST_DONE_IRQ  = 1;
	localparam int ST_ACTIVE    = 2;
	localparam int ST_REQ       = 3;
	localparam int ST_START     = 15;
	localparam int ST_CNTR_LSB  = 16;
	localparam int ST_STATE_LSB = 30;

	localparam int DMA_CNT_W = 9;
	localparam int DMA_ST_W  = 2;

	typedef logic [DMA_CNT_W-1:0] dma_cnt_t;

	localparam logic     I2S_EN_RST  = 1'b1;
	localparam dma_cnt_t DMA_CNT_RST = 9'd4;

endpackage

`default_nettype wire

/* verilog/i2s_map_pkg.sv */
`default_nettype none

// ----------------------------------------------------------------------
// Bus widths and register address map
// ----------------------------------------------------------------------
package i2s_map_pkg;

	localparam int ADR_W  = 10;  // Register and RAM window address
	localparam int DAT_W  = 32;
	localparam int BSTB_W = 4;   // Byte lanes

	typedef logic [ADR_W-1:0]  wb_adr_t;
	typedef logic [DAT_W-1:0]  wb_dat_t;
	typedef logic [BSTB_W-1:0] wb_bstb_t;

	// Register offsets inside the block
	localparam wb_adr_t I2S_EN_ADR   = 10'h000;
	localparam wb_adr_t INTR_STS_ADR = 10'h002;
	localparam wb_adr_t INTR_EN_ADR  = 10'h003;
	localparam wb_adr_t DMA_EN_ADR   = 10'h008;
	localparam wb_adr_t DMA_STS_ADR  = 10'h009;  // Read only
	localparam wb_adr_t DMA_CNT_ADR  = 10'h00A;

	// RAM windows
	localparam int COS_SIN_ADR_W = 9;   // Coefficient RAM depth 512
	localparam int RAM_HALF_W    = 16;  // One half of a sample word

endpackage

`default_nettype wire

/* verilog/irq_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module irq_regs (
	input  wire                  WBs_CLK_i,
	input  wire                  WBs_RST_i,
	input  wire                  wr_irq_en_i,
	input  wire                  wr_irq_sts_i,
	input  wire                  DMA_Done_i,
	input  wire                  i2s_dis_i,
	input  wire                  f_calc_done_i,
	input  i2s_map_pkg::wb_dat_t WBs_DAT_i,
	output logic                 DMA_Done_IRQ_o,
	output logic                 I2S_Dis_IRQ_o,
	output logic                 f_Done_IRQ_o,
	output logic                 DMA_Done_IRQ_EN_o,
	output logic                 I2S_Dis_IRQ_EN_o,
	output logic                 f_Done_IRQ_EN_o
);

	import i2s_field_pkg::*;

	// Status slots: 0 DMA done, 1 I2S disable, 2 filter done
	logic [2:0] sts_evt;
	logic [2:0] sts_wdat;
	logic [2:0] sts_q;

	assign sts_evt  = {f_calc_done_i, i2s_dis_i, DMA_Done_i};
	assign sts_wdat = {WBs_DAT_i[IRQ_F_DONE_STS_BIT],
	                   WBs_DAT_i[IRQ_I2S_DIS_BIT],
	                   WBs_DAT_i[IRQ_DMA_DONE_BIT]};

	// ------------------------------------------------------------------
	// Status bits, hardware event beats software write
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			sts_q <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (sts_evt[i])
					sts_q[i] <= 1'b1;
				else if (wr_irq_sts_i)
					sts_q[i] <= sts_wdat[i];  // Write zero to clear
			end
		end
	end

	assign DMA_Done_IRQ_o = sts_q[0];
	assign I2S_Dis_IRQ_o  = sts_q[1];
	assign f_Done_IRQ_o   = sts_q[2];

	// ------------------------------------------------------------------
	// Enable bits
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			DMA_Done_IRQ_EN_o <= 1'b0;
			I2S_Dis_IRQ_EN_o  <= 1'b0;
			f_Done_IRQ_EN_o   <= 1'b0;
		end
		else if (wr_irq_en_i)
		begin
			DMA_Done_IRQ_EN_o <= WBs_DAT_i[IRQ_DMA_DONE_BIT];
			I2S_Dis_IRQ_EN_o  <= WBs_DAT_i[IRQ_I2S_DIS_BIT];
			f_Done_IRQ_EN_o   <= WBs_DAT_i[IRQ_F_DONE_BIT];  // Bit 1 here, bit 2 in status
		end
	end

endmodule

`default_nettype wire

/* verilog/reg_read_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_read_mux (
	input  i2s_map_pkg::wb_adr_t    WBs_ADR_i,
	input  wire                     I2S_S_EN_i,
	input  wire                     f_RAM_mast_sel_i,
	input  wire                     cs_ram_rd_ctrl_i,
	input  wire                     dma_en_i,
	input  wire                     DMA_Start_i,
	input  i2s_field_pkg::dma_cnt_t DMA_CNT_i,
	input  wire                     DMA_Done_IRQ_i,
	input  wire                     I2S_Dis_IRQ_i,
	input  wire                     f_Done_IRQ_i,
	input  wire                     DMA_Done_IRQ_EN_i,
	input  wire                     I2S_Dis_IRQ_EN_i,
	input  wire                     f_Done_IRQ_EN_i,
	input  wire                     DMA_Busy_i,
	input  wire                     DMA_Active_i,
	input  wire                     DMA_REQ_i,
	input  i2s_field_pkg::dma_cnt_t dma_cntr_i,
	input  wire [i2s_field_pkg::DMA_ST_W-1:0] dma_st_i,
	output i2s_map_pkg::wb_dat_t    WBs_DAT_o
);

	import i2s_map_pkg::*;
	import i2s_field_pkg::*;

	always_comb
	begin
		WBs_DAT_o = '0;  // Unmapped offsets read zero
		case (WBs_ADR_i)
			I2S_EN_ADR:
			begin
				WBs_DAT_o[CTRL_I2S_EN_BIT]   = I2S_S_EN_i;
				WBs_DAT_o[CTRL_MAST_SEL_BIT] = f_RAM_mast_sel_i;
				WBs_DAT_o[CTRL_CS_RD_BIT]    = cs_ram_rd_ctrl_i;
			end
			INTR_STS_ADR:
			begin
				WBs_DAT_o[IRQ_DMA_DONE_BIT]   = DMA_Done_IRQ_i;
				WBs_DAT_o[IRQ_F_DONE_STS_BIT] = f_Done_IRQ_i;
				WBs_DAT_o[IRQ_I2S_DIS_BIT]    = I2S_Dis_IRQ_i;
			end
			INTR_EN_ADR:
			begin
				WBs_DAT_o[IRQ_DMA_DONE_BIT] = DMA_Done_IRQ_EN_i;
				WBs_DAT_o[IRQ_F_DONE_BIT]   = f_Done_IRQ_EN_i;
				WBs_DAT_o[IRQ_I2S_DIS_BIT]  = I2S_Dis_IRQ_EN_i;
			end
			DMA_EN_ADR:  WBs_DAT_o[0] = dma_en_i;
			DMA_STS_ADR:
			begin
				WBs_DAT_o[ST_BUSY]                      = DMA_Busy_i;
				WBs_DAT_o[ST_DONE_IRQ]                  = DMA_Done_IRQ_i;
				WBs_DAT_o[ST_ACTIVE]                    = DMA_Active_i;
				WBs_DAT_o[ST_REQ]                       = DMA_REQ_i;
				WBs_DAT_o[ST_START]                     = DMA_Start_i;
				WBs_DAT_o[ST_CNTR_LSB +: DMA_CNT_W]     = dma_cntr_i;  // Live engine count
				WBs_DAT_o[ST_STATE_LSB +: DMA_ST_W]     = dma_st_i;
			end
			DMA_CNT_ADR: WBs_DAT_o[DMA_CNT_W-1:0] = DMA_CNT_i;
			default:     WBs_DAT_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/wb_bus_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_bus_decode (
	input  wire                   WBs_CLK_i,
	input  wire                   WBs_RST_i,
	input  i2s_map_pkg::wb_adr_t  WBs_ADR_i,
	input  wire                   WBs_CYC_i,
	input  wire                   WBs_CYC_I2SRx_Real_RAM_i,
	input  wire                   WBs_CYC_I2SRx_Img_RAM_i,
	input  wire                   WBs_CYC_f_CosSin_RAM_i,
	input  wire                   WBs_STB_i,
	input  wire                   WBs_WE_i,
	input  i2s_map_pkg::wb_bstb_t WBs_BYTE_STB_i,
	output logic                  wr_ctrl_o,
	output logic                  wr_dma_en_o,
	output logic                  wr_dma_cnt_o,
	output logic                  wr_irq_en_o,
	output logic                  wr_irq_sts_o,
	output logic                  sram_wen_o,
	output logic                  cs_ram_wen_o,
	output logic                  WBs_ACK_o
);

	import i2s_map_pkg::*;

	logic ack_q;       // Acknowledge to the master
	logic ack_hold_q;  // Quiet cycle after each ack
	logic any_cyc;
	logic cyc_open;
	logic wr_qual;
	logic reg_wr;
	logic sram_cyc;

	assign sram_cyc = WBs_CYC_I2SRx_Real_RAM_i | WBs_CYC_I2SRx_Img_RAM_i;
	assign any_cyc  = WBs_CYC_i | sram_cyc | WBs_CYC_f_CosSin_RAM_i;
	assign cyc_open = any_cyc & WBs_STB_i;

	// Write qualifier shared by every target
	assign wr_qual = WBs_STB_i & WBs_WE_i & ~ack_q;
	assign reg_wr  = WBs_CYC_i & wr_qual & WBs_BYTE_STB_i[0];

	// ------------------------------------------------------------------
	// Register write strobes
	// ------------------------------------------------------------------
	assign wr_ctrl_o    = reg_wr & (WBs_ADR_i == I2S_EN_ADR);
	assign wr_dma_en_o  = reg_wr & (WBs_ADR_i == DMA_EN_ADR);
	assign wr_dma_cnt_o = reg_wr & (WBs_ADR_i == DMA_CNT_ADR);
	assign wr_irq_en_o  = reg_wr & (WBs_ADR_i == INTR_EN_ADR);
	assign wr_irq_sts_o = reg_wr & (WBs_ADR_i == INTR_STS_ADR);

	// RAM windows take any address in their cycle
	assign sram_wen_o   = sram_cyc & wr_qual;
	assign cs_ram_wen_o = WBs_CYC_f_CosSin_RAM_i & wr_qual;

	// ------------------------------------------------------------------
	// Acknowledge, one cycle high then one held off
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			ack_q      <= 1'b0;
			ack_hold_q <= 1'b0;
		end
		else
		begin
			ack_q      <= cyc_open & ~ack_q & ~ack_hold_q;
			ack_hold_q <= ack_q;
		end
	end

	assign WBs_ACK_o = ack_q;

endmodule

`default_nettype wire
